//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  cond_t;     // equals the branch opcode
    typedef logic [3:0]  ccr_t;      // carry, negative, overflow, zero

    typedef enum logic [2:0] {
        mode_inh2   = 3'd0,
        mode_imm3   = 3'd1,
        mode_regind = 3'd2,
        mode_reg    = 3'd3,
        mode_inh    = 3'd4,
        mode_imm2   = 3'd5,
        mode_dir    = 3'd6,
        mode_imm3a  = 3'd7
    } mode_t;

    typedef enum logic [3:0] {
        alu_and = 4'd0,
        alu_or  = 4'd1,
        alu_add = 4'd2,
        alu_sub = 4'd3,
        alu_xor = 4'd4,
        alu_shl = 4'd5,
        alu_shr = 4'd6,
        alu_asr = 4'd7
    } alu_op_t;

    typedef enum logic [3:0] {
        i_nop, i_alu, i_cmp, i_unary, i_move, i_load_imm,
        i_branch, i_jump, i_load, i_store, i_illegal
    } instr_class_t;

    typedef enum logic [2:0] {
        st_fetch, st_exec, st_store, st_load, st_load2, st_fault
    } state_t;

    localparam word_t      reset_pc   = 32'hffc0_0000;  // monitor base
    localparam logic [1:0] fetch_wait = 2'd3;
    localparam word_t      pc_step    = 32'd2;

endpackage

`default_nettype wire

//--- rtl/cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode
    import cpu_pkg::*;
(
    input  word_t        ir,
    input  half_t        ext,
    output instr_class_t cls,
    output alu_op_t      alu_op,
    output cond_t        cond,
    output reg_addr_t    rd,
    output reg_addr_t    rs1,
    output reg_addr_t    rs2,
    output word_t        imm,
    output logic         src2_imm,
    output logic [1:0]   length
);

    mode_t      mode;
    logic [7:0] opcode;

    assign mode   = mode_t'(ir[31:29]);
    assign opcode = ir[31] ? ((mode == mode_inh) ? {ir[28:26], 5'b00000} : ir[28:21])
                           : {ir[28:26], ir[15:11]};
    assign cond   = opcode[3:0];
    assign rd     = ir[20:16];

    always_comb begin
        case (mode)
            mode_inh:              imm = 32'd1;  // step for inc and dec
            mode_imm2:             imm = (opcode == 8'h11) ? {16'h0000, ir[15:0]}
                                                           : {{16{ir[15]}}, ir[15:0]};
            mode_regind:           imm = {{21{ir[10]}}, ir[10:0]};
            mode_imm3:             imm = {{16{ext[15]}}, ext};
            mode_imm3a, mode_dir:  imm = {ir[15:0], ext};
            default:               imm = '0;
        endcase
    end

    always_comb begin
        cls      = i_illegal;
        alu_op   = alu_add;
        rs1      = ir[25:21];
        rs2      = ir[4:0];
        src2_imm = 1'b0;
        length   = 2'd2;
        case (mode)
            mode_inh: begin
                length = 2'd1;
                case (opcode)
                    8'h00: cls = i_nop;
                    8'h40: begin
                        cls    = i_cmp;
                        alu_op = alu_sub;
                        rs1    = ir[20:16];
                        rs2    = ir[25:21];
                    end
                    8'h60, 8'h80: begin
                        cls      = i_alu;
                        alu_op   = opcode[7] ? alu_sub : alu_add;
                        rs1      = ir[20:16];
                        src2_imm = 1'b1;
                    end
                    8'he0: cls = i_move;
                    default: cls = i_illegal;
                endcase
            end
            mode_inh2: begin
                if (opcode == 8'h02 || opcode == 8'h22) begin
                    cls    = i_unary;
                    alu_op = opcode[5] ? alu_sub : alu_xor;  // neg or com
                end
            end
            mode_imm2: begin
                if (opcode == 8'h10 || opcode == 8'h11) cls = i_load_imm;
                else if (opcode <= 8'h0b) cls = i_branch;
            end
            mode_reg, mode_imm3: begin
                length = (mode == mode_imm3) ? 2'd3 : 2'd2;
                if (opcode[7:3] == 5'b00000) begin
                    cls      = i_alu;
                    alu_op   = alu_op_t'(opcode[3:0]);
                    src2_imm = (mode == mode_imm3);
                end
            end
            mode_imm3a: begin
                length = 2'd3;
                if (opcode == 8'h00) cls = i_load_imm;
            end
            mode_regind, mode_dir: begin
                length = (mode == mode_dir) ? 2'd3 : 2'd2;
                rs2    = ir[20:16];  // store data
                case (opcode)
                    8'h02: cls = i_store;
                    8'h03: cls = i_load;
                    8'h0a: begin
                        if (mode == mode_regind) begin
                            cls      = i_alu;  // lda
                            src2_imm = 1'b1;
                        end
                    end
                    8'ha0: if (mode == mode_regind) cls = i_jump;
                    8'h80: if (mode == mode_dir) cls = i_jump;
                    default: cls = i_illegal;
                endcase
            end
            default: cls = i_illegal;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute
    import cpu_pkg::*;
(
    input  instr_class_t cls,
    input  alu_op_t      alu_op,
    input  cond_t        cond,
    input  word_t        a,
    input  word_t        b,
    input  word_t        imm,
    input  logic         src2_imm,
    input  word_t        pc,
    input  ccr_t         flags,
    output word_t        result,
    output ccr_t         flags_out,
    output logic         branch_taken,
    output word_t        branch_target
);

    word_t       op2;
    word_t       alu_res;
    logic [32:0] sum;
    logic [32:0] diff;
    logic        carry;
    logic        overflow;
    logic        c;
    logic        n;
    logic        v;
    logic        z;
    logic        cond_ok;

    assign op2          = src2_imm ? imm : b;
    assign sum          = {1'b0, a} + {1'b0, op2};
    assign diff         = {1'b0, a} - {1'b0, op2};  // bit 32 is the borrow
    assign {c, n, v, z} = flags;

    always_comb begin
        case (alu_op)
            alu_and: alu_res = a & op2;
            alu_or:  alu_res = a | op2;
            alu_add: alu_res = sum[31:0];
            alu_sub: alu_res = diff[31:0];
            alu_xor: alu_res = a ^ op2;
            alu_shl: alu_res = a << op2[4:0];
            alu_shr: alu_res = a >> op2[4:0];
            alu_asr: alu_res = word_t'($signed(a) >>> op2[4:0]);
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        if (cls == i_alu || cls == i_cmp) begin
            if (alu_op == alu_add) begin
                carry    = sum[32];
                overflow = (a[31] == op2[31]) && (sum[31] != a[31]);
            end else if (alu_op == alu_sub) begin
                carry    = diff[32];
                overflow = (a[31] != op2[31]) && (diff[31] != a[31]);
            end
        end
    end

    always_comb begin
        case (cls)
            i_alu, i_cmp:            result = alu_res;
            i_unary:                 result = (alu_op == alu_sub) ? 32'd0 - a : ~a;
            i_move:                  result = a;
            i_load_imm:              result = imm;
            i_load, i_store, i_jump: result = a + imm;  // effective address
            default:                 result = '0;
        endcase
    end

    assign flags_out = {carry, result[31], overflow, (result == 32'd0)};

    always_comb begin
        case (cond)
            4'd0:    cond_ok = 1'b1;
            4'd1:    cond_ok = z;
            4'd2:    cond_ok = ~z;
            4'd3:    cond_ok = ~(z | c);
            4'd4:    cond_ok = ~(z | (n ^ v));
            4'd5:    cond_ok = ~(n ^ v);
            4'd6:    cond_ok = z | (n ^ v);
            4'd7:    cond_ok = n ^ v;
            4'd8:    cond_ok = ~c;
            4'd9:    cond_ok = c;
            4'd10:   cond_ok = c | z;
            default: cond_ok = 1'b0;  // brn
        endcase
    end

    assign branch_taken  = (cls == i_branch) && cond_ok;
    assign branch_target = pc + imm;

endmodule

`default_nettype wire

//--- rtl/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     write_data,
    input  logic      write_en,
    output word_t     data1,
    output word_t     data2
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[rd] <= write_data;
        end
    end

    assign data1 = regs[rs1];
    assign data2 = regs[rs2];

endmodule

`default_nettype wire

//--- rtl/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  half_t        data_in,
    input  instr_class_t cls,
    input  logic [1:0]   length,
    input  word_t        result,
    input  ccr_t         flags_out,
    input  logic         branch_taken,
    input  word_t        branch_target,
    input  word_t        rdata2,
    input  word_t        imm,
    output word_t        ir,
    output half_t        ext,
    output word_t        pc,
    output ccr_t         ccr,
    output word_t        addrbus,
    output half_t        data_out,
    output logic         write_out,
    output logic         write_en,
    output word_t        write_data
);

    state_t     state;
    logic [1:0] wait_cnt;
    logic [1:0] hw_cnt;
    word_t      mar;
    half_t      mdr;
    word_t      addr;
    logic       capture;
    logic       last_half;

    assign capture = (state == st_fetch) && (wait_cnt == 2'd1);
    // first halfword is not in ir yet, so its mode is taken from the bus
    assign last_half = (hw_cnt == 2'd0) ? (mode_t'(data_in[15:13]) == mode_inh)
                                        : (hw_cnt + 2'd1 == length);
    assign addr = (length == 2'd3) ? imm : result;  // dir forms are absolute

    assign addrbus  = (state == st_store || state == st_load || state == st_load2) ? mar : pc;
    assign data_out = mdr;
    assign write_en = (state == st_load2) ||
                      ((state == st_exec) && (cls == i_alu || cls == i_unary ||
                                              cls == i_move || cls == i_load_imm));
    assign write_data = (state == st_load2) ? {16'h0000, data_in} : result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_fetch;
            wait_cnt  <= 2'd0;
            hw_cnt    <= 2'd0;
            pc        <= reset_pc;
            ccr       <= '0;
            write_out <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (wait_cnt == 2'd0) begin
                        wait_cnt <= fetch_wait;  // load cycle
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                        if (capture) begin
                            pc <= pc + pc_step;
                            if (last_half) begin
                                hw_cnt <= 2'd0;
                                state  <= st_exec;
                            end else begin
                                hw_cnt <= hw_cnt + 2'd1;
                            end
                        end
                    end
                end
                st_exec: begin
                    state <= st_fetch;
                    case (cls)
                        i_cmp: begin
                            if (wait_cnt == 2'd0) begin
                                wait_cnt <= 2'd2;
                                state    <= st_exec;
                            end else begin
                                wait_cnt <= wait_cnt - 2'd1;
                                if (wait_cnt == 2'd1) ccr <= flags_out;
                                else state <= st_exec;
                            end
                        end
                        i_branch: if (branch_taken) pc <= branch_target;
                        i_jump:   pc <= addr;
                        i_store: begin
                            write_out <= 1'b1;
                            state     <= st_store;
                        end
                        i_load:    state <= st_load;
                        i_illegal: state <= st_fault;
                        default:   state <= st_fetch;
                    endcase
                end
                st_store: begin
                    write_out <= 1'b0;
                    state     <= st_fetch;
                end
                st_load:  state <= st_load2;
                st_load2: state <= st_fetch;
                default:  state <= st_fault;  // fault holds
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            case (hw_cnt)
                2'd0:    ir[31:16] <= data_in;
                2'd1:    ir[15:0]  <= data_in;
                default: ext       <= data_in;
            endcase
        end
        if (state == st_exec && (cls == i_store || cls == i_load)) begin
            mar <= addr;
        end
        if (state == st_exec && cls == i_store) begin
            mdr <= rdata2[15:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output word_t addrbus,
    input  half_t data_in,
    output half_t data_out,
    output logic  write_out,
    output ccr_t  ccr
);

    word_t        ir;
    half_t        ext;
    word_t        pc;
    instr_class_t cls;
    alu_op_t      alu_op;
    cond_t        cond;
    reg_addr_t    rd;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    word_t        imm;
    logic         src2_imm;
    logic [1:0]   length;
    word_t        rdata1;
    word_t        rdata2;
    word_t        result;
    ccr_t         flags_out;
    logic         branch_taken;
    word_t        branch_target;
    logic         write_en;
    word_t        write_data;

    cpu_decode u_decode (
        .ir(ir), .ext(ext), .cls(cls), .alu_op(alu_op), .cond(cond), .rd(rd),
        .rs1(rs1), .rs2(rs2), .imm(imm), .src2_imm(src2_imm), .length(length)
    );

    cpu_execute u_execute (
        .cls(cls), .alu_op(alu_op), .cond(cond), .a(rdata1), .b(rdata2), .imm(imm),
        .src2_imm(src2_imm), .pc(pc), .flags(ccr), .result(result), .flags_out(flags_out),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    cpu_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd), .write_data(write_data),
        .write_en(write_en), .data1(rdata1), .data2(rdata2)
    );

    cpu_control u_control (
        .clk(clk), .rst_n(rst_n), .data_in(data_in), .cls(cls), .length(length),
        .result(result), .flags_out(flags_out), .branch_taken(branch_taken),
        .branch_target(branch_target), .rdata2(rdata2), .imm(imm), .ir(ir), .ext(ext),
        .pc(pc), .ccr(ccr), .addrbus(addrbus), .data_out(data_out), .write_out(write_out),
        .write_en(write_en), .write_data(write_data)
    );

endmodule

`default_nettype wire

//--- test/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem
    import cpu_pkg::*;
(
    input  logic  clk,
    input  word_t addr,
    output half_t rdata,
    input  half_t wdata,
    input  logic  we
);

    half_t mem [4096];  // filled by the testbench before reset

    assign rdata = mem[addr[12:1]];  // combinational read

    always @(posedge clk) begin
        if (we) begin
            mem[addr[12:1]] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    logic  clk;
    logic  rst_n;
    word_t addrbus;
    half_t data_in;
    half_t data_out;
    logic  write_out;
    ccr_t  ccr;

    integer      seed = 32'h5fc2_f90d;
    int          ptr = 0;
    int          store_cnt = 0;
    int          cycles = 0;
    int          limit = 100000;
    word_t       model [32];
    ccr_t        exp_ccr = 4'h0;
    logic [51:0] exp_q [$];  // ccr, address, data
    word_t       end_addr;
    word_t       held;

    cpu_top uut (
        .clk(clk), .rst_n(rst_n), .addrbus(addrbus), .data_in(data_in),
        .data_out(data_out), .write_out(write_out), .ccr(ccr)
    );

    tb_mem u_mem (
        .clk(clk), .addr(addrbus), .rdata(data_in), .wdata(data_out), .we(write_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("Simulation failed");
        $display("%s", what);
        $fatal(1);
    endtask

    task automatic report_value(input string name, input word_t got, input word_t exp);
        $display("Simulation failed");
        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        $fatal(1);
    endtask

    function automatic half_t fill_value(input int idx);
        return {4'h5, idx[11:0]} ^ {idx[7:0], 8'h3c};  // spreads all 12 index bits
    endfunction

    function automatic word_t addr_of(input int idx);
        return reset_pc + word_t'(2 * idx);
    endfunction

    function automatic word_t alu_ref(input logic [3:0] op, input word_t x, input word_t y);
        case (op)
            4'd0:    return x & y;
            4'd1:    return x | y;
            4'd2:    return x + y;
            4'd3:    return x - y;
            4'd4:    return x ^ y;
            4'd5:    return x << y[4:0];
            4'd6:    return x >> y[4:0];
            default: return word_t'($signed(x) >>> y[4:0]);
        endcase
    endfunction

    function automatic ccr_t cmp_ref(input word_t x, input word_t y);
        word_t d;
        d = x - y;
        return {x < y, d[31], (x[31] != y[31]) && (d[31] != x[31]), x == y};
    endfunction

    function automatic bit branch_ref(input logic [3:0] c, input word_t x, input word_t y);
        case (c)
            4'd0:    return 1'b1;
            4'd1:    return x == y;
            4'd2:    return x != y;
            4'd3:    return x > y;
            4'd4:    return $signed(x) > $signed(y);
            4'd5:    return $signed(x) >= $signed(y);
            4'd6:    return $signed(x) <= $signed(y);
            4'd7:    return $signed(x) < $signed(y);
            4'd8:    return x >= y;
            4'd9:    return x < y;
            4'd10:   return x <= y;
            default: return 1'b0;
        endcase
    endfunction

    task automatic put(input half_t h);
        u_mem.mem[ptr] = h;
        ptr++;
    endtask

    // two-halfword formats with the register fields in the first halfword
    task automatic emit_two(input logic [2:0] mode, input logic [2:0] hi, input reg_addr_t rb,
                            input reg_addr_t ra, input logic [4:0] lo, input logic [10:0] low);
        put({mode, hi, rb, ra});
        put({lo, low});
    endtask

    task automatic emit_ldi(input reg_addr_t r, input word_t v);
        put({3'b111, 8'h00, r});
        put(v[31:16]);
        put(v[15:0]);
        model[r] = v;
    endtask

    task automatic emit_std(input reg_addr_t r, input word_t a);
        put({3'b110, 8'h02, r});
        put(a[31:16]);
        put(a[15:0]);
    endtask

    task automatic expect_store(input word_t a, input half_t d);
        exp_q.push_back({exp_ccr, a, d});
    endtask

    task automatic check_reg(input reg_addr_t r);
        word_t a;
        a = 32'h0000_1000 + word_t'(2 * store_cnt);
        store_cnt++;
        emit_std(r, a);
        expect_store(a, model[r][15:0]);
    endtask

    task automatic emit_alu_ri(input logic [3:0] op, input reg_addr_t ra, input reg_addr_t rb,
                               input half_t k);
        emit_two(3'b001, 3'b000, rb, ra, {1'b0, op}, 11'd0);
        put(k);
        model[ra] = alu_ref(op, model[rb], {{16{k[15]}}, k});
    endtask

    task automatic branch_block(input logic [3:0] c);
        word_t a;
        a = 32'h0000_1000 + word_t'(2 * store_cnt);
        store_cnt++;
        put({3'b101, 4'h0, c, 5'd0});
        put(16'd10);
        emit_std(6, a);  // marker B
        put({3'b101, 8'h00, 5'd0});
        put(16'd6);
        emit_std(5, a);  // marker A
        expect_store(a, branch_ref(c, model[7], model[8]) ? model[5][15:0] : model[6][15:0]);
    endtask

    task automatic build_program();
        half_t k;
        word_t x [3];
        word_t y [3];
        int    t;
        word_t dest;
        emit_ldi(1, $random(seed));
        emit_ldi(2, $random(seed));
        for (int op = 0; op < 8; op++) begin
            emit_two(3'b011, 3'b000, 1, 3, {1'b0, 4'(op)}, 11'd2);  // rc is r2
            model[3] = alu_ref(4'(op), model[1], model[2]);
            check_reg(3);
            k = 16'($random(seed));
            emit_alu_ri(4'(op), 4, 1, k);
            check_reg(4);
        end
        put({3'b100, 3'b011, 5'd0, 5'd1});  // inc r1
        model[1] = model[1] + 1;
        check_reg(1);
        put({3'b100, 3'b100, 5'd0, 5'd2});  // dec r2
        model[2] = model[2] - 1;
        check_reg(2);
        put({3'b100, 3'b111, 5'd1, 5'd3});  // mov r3 from r1
        model[3] = model[1];
        check_reg(3);
        emit_two(3'b000, 3'b000, 2, 4, 5'b00010, 11'd0);  // com
        model[4] = ~model[2];
        check_reg(4);
        emit_two(3'b000, 3'b001, 1, 4, 5'b00010, 11'd0);  // neg
        model[4] = 32'd0 - model[1];
        check_reg(4);
        for (int u = 0; u < 2; u++) begin
            put({3'b101, 7'h08, 1'(u), 5'd3});  // ldis, then ldiu
            put(16'h8123);
            model[3] = (u == 0) ? 32'hffff_8123 : 32'h0000_8123;
            check_reg(3);
            emit_alu_ri(4'd6, 4, 3, 16'd16);  // upper half into view
            check_reg(4);
        end
        emit_two(3'b010, 3'b000, 1, 4, 5'b01010, 11'h7fb);  // lda r4, r1 - 5
        model[4] = model[1] - 5;
        check_reg(4);

        emit_ldi(5, 32'h0000_a5a5);
        emit_ldi(6, 32'h0000_b6b6);
        x[0] = $random(seed);
        y[0] = x[0];
        x[1] = 32'h8000_0000;
        y[1] = 32'h0000_0001;
        x[2] = $random(seed);
        y[2] = $random(seed);
        for (int p = 0; p < 3; p++) begin
            emit_ldi(7, x[p]);
            emit_ldi(8, y[p]);
            put({3'b100, 3'b010, 5'd8, 5'd7});  // cmp r7, r8
            exp_ccr = cmp_ref(x[p], y[p]);
            for (int c = 0; c < 12; c++) begin
                branch_block(4'(c));
            end
        end

        emit_ldi(9, 32'h0000_1400);
        emit_ldi(10, $random(seed));
        emit_two(3'b010, 3'b000, 9, 10, 5'b00010, 11'h7fa);  // st r10, [r9 - 6]
        expect_store(32'h0000_13fa, model[10][15:0]);
        emit_two(3'b010, 3'b000, 9, 11, 5'b00011, 11'h7fa);  // ld r11, [r9 - 6]
        model[11] = {16'h0000, model[10][15:0]};
        check_reg(11);
        emit_alu_ri(4'd6, 11, 11, 16'd16);
        check_reg(11);
        put({3'b110, 8'h03, 5'd12});  // ldd r12 from preloaded data
        put(16'h0000);
        put(16'h1e00);
        model[12] = {16'h0000, fill_value(12'hf00)};
        check_reg(12);

        t = ptr + 3 + 2 + 3;
        emit_ldi(9, addr_of(t) - 8);
        emit_two(3'b010, 3'b101, 9, 0, 5'b00000, 11'd8);  // jmp [r9 + 8]
        emit_std(5, 32'h0000_1ffe);  // skipped
        check_reg(6);
        t = ptr + 3 + 3;
        dest = addr_of(t);
        put({3'b110, 8'h80, 5'd0});  // jmpd
        put(dest[31:16]);
        put(dest[15:0]);
        emit_std(6, 32'h0000_1ffe);  // skipped
        check_reg(5);

        put({3'b100, 3'b001, 10'd0});  // unimplemented opcode
        end_addr = addr_of(ptr);
    endtask

    task automatic check_idle_outputs();
        assert (write_out == 1'b0) else report_value("write_out", 32'(write_out), 32'd0);
        assert (ccr == 4'h0) else report_value("ccr", 32'(ccr), 32'd0);
        assert (addrbus == reset_pc) else report_value("addrbus", addrbus, reset_pc);
    endtask

    always @(posedge clk) begin : store_check
        logic [51:0] e;
        if (rst_n && write_out) begin
            assert (exp_q.size() != 0)
                else report_failure("store seen with no store left to expect");
            e = exp_q.pop_front();
            assert (addrbus == e[47:16]) else report_value("addrbus", addrbus, e[47:16]);
            assert (data_out == e[15:0])
                else report_value("data_out", {16'h0000, data_out}, {16'h0000, e[15:0]});
            assert (ccr == e[51:48]) else report_value("ccr", 32'(ccr), 32'(e[51:48]));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            report_failure("timeout: program did not reach the fault state in time");
        end
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            u_mem.mem[i] = fill_value(i);
        end
        build_program();
        limit = ptr * 8 + 300;  // worst case per halfword plus reset and fault window
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        while (exp_q.size() != 0) @(negedge clk);
        while (addrbus != end_addr) @(negedge clk);
        held = addrbus;
        repeat (100) begin
            @(negedge clk);
            assert (write_out == 1'b0)
                else report_failure("write_out went high in the fault state");
            assert (addrbus == held) else report_value("addrbus", addrbus, held);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/cpu_pkg.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/cpu_regfile.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
test/tb_mem.sv
test/tb_cpu.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f flist.f -o sim_cpu \
    && ./obj_dir/sim_cpu > sim.log 2>&1
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
